// File: sys_pkg.sv
// Shared bus widths, address map, version constant and enum types
package sys_pkg;

  // Bus widths
  localparam int ADDR_WIDTH = 15;
  localparam int DATA_WIDTH = 16;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  // Top three address bits pick the region
  localparam int REGION_W   = 3;
  localparam int REGION_MSB = ADDR_WIDTH - 1;

  localparam logic [REGION_W-1:0] REGION_MEM  = 3'b000;  // 0x0000
  localparam logic [REGION_W-1:0] REGION_GPIO = 3'b100;  // 0x4000

  // Boot memory
  localparam int MEM_DEPTH     = 256;
  localparam int MEM_AW        = $clog2(MEM_DEPTH);
  localparam int VERSION_WORDS = 4;

  // Word 0 holds bits 15:0, word 3 holds bits 63:48
  localparam logic [63:0] SYS_VERSION = 64'hBAD2_6032_000A_0001;

  // GPIO pin count
  localparam int GPIO_WIDTH = 16;

  // ----------------------------------------
  // Types
  // ----------------------------------------
  typedef enum logic [1:0] {
    RGN_MEM,
    RGN_GPIO,
    RGN_NONE
  } region_e;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_M0,
    ARB_M1
  } arb_state_e;

  // Code 3 is unused and reads as zero
  typedef enum logic [1:0] {
    GPIO_DIR = 2'd0,
    GPIO_OUT = 2'd1,
    GPIO_IN  = 2'd2
  } gpio_reg_e;

endpackage

// File: bus_arbiter.sv
// Two-master round-robin bus arbiter
// Registers the granted request onto the shared bus and returns its response
module bus_arbiter import sys_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  // Master 0
  input  logic                  m0_cyc_i,
  input  logic                  m0_stb_i,
  input  logic                  m0_we_i,
  input  logic [ADDR_WIDTH-1:0] m0_adr_i,
  input  logic [DATA_WIDTH-1:0] m0_dat_i,
  output logic [DATA_WIDTH-1:0] m0_dat_o,
  output logic                  m0_ack_o,
  // Master 1
  input  logic                  m1_cyc_i,
  input  logic                  m1_stb_i,
  input  logic                  m1_we_i,
  input  logic [ADDR_WIDTH-1:0] m1_adr_i,
  input  logic [DATA_WIDTH-1:0] m1_dat_i,
  output logic [DATA_WIDTH-1:0] m1_dat_o,
  output logic                  m1_ack_o,
  // Shared bus
  output logic                  bus_stb_o,
  output logic                  bus_we_o,
  output logic [ADDR_WIDTH-1:0] bus_adr_o,
  output logic [DATA_WIDTH-1:0] bus_wdat_o,
  input  logic [DATA_WIDTH-1:0] bus_rdat_i,
  input  logic                  bus_ack_i
);

  arb_state_e state_q;
  logic       last_m1_q;
  logic       req0;
  logic       req1;
  logic       pick_m1;
  logic       done;

  assign req0 = m0_cyc_i & m0_stb_i;
  assign req1 = m1_cyc_i & m1_stb_i;

  // On a tie the master not served last wins
  assign pick_m1 = req1 & (~req0 | ~last_m1_q);

  // Slave answered the current transfer
  assign done = bus_stb_o & bus_ack_i;

  // ----------------------------------------
  // Grant FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= ARB_IDLE;
      last_m1_q <= 1'b1;
      bus_stb_o <= 1'b0;
      m0_ack_o  <= 1'b0;
      m1_ack_o  <= 1'b0;
    end else begin
      m0_ack_o <= 1'b0;
      m1_ack_o <= 1'b0;
      case (state_q)
        ARB_IDLE: begin
          if (req0 | req1) begin
            state_q   <= pick_m1 ? ARB_M1 : ARB_M0;
            last_m1_q <= pick_m1;
            bus_stb_o <= 1'b1;
          end
        end
        default: begin
          // Ack went out last cycle, release the bus
          if (m0_ack_o | m1_ack_o) begin
            state_q <= ARB_IDLE;
          end else if (done) begin
            bus_stb_o <= 1'b0;
            m0_ack_o  <= (state_q == ARB_M0);
            m1_ack_o  <= (state_q == ARB_M1);
          end
        end
      endcase
    end
  end

  // Request payload, captured while idle
  always_ff @(posedge clk) begin
    if (state_q == ARB_IDLE) begin
      bus_we_o   <= pick_m1 ? m1_we_i  : m0_we_i;
      bus_adr_o  <= pick_m1 ? m1_adr_i : m0_adr_i;
      bus_wdat_o <= pick_m1 ? m1_dat_i : m0_dat_i;
    end
  end

  // Read data to the owner only, zero elsewhere
  always_ff @(posedge clk) begin
    m0_dat_o <= (done && state_q == ARB_M0) ? bus_rdat_i : '0;
    m1_dat_o <= (done && state_q == ARB_M1) ? bus_rdat_i : '0;
  end

endmodule

// File: bus_decoder.sv
// Address region decoder with slave strobe routing and response merge
module bus_decoder import sys_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  // Shared bus from the arbiter
  input  logic                  bus_stb_i,
  input  logic [ADDR_WIDTH-1:0] bus_adr_i,
  output logic [DATA_WIDTH-1:0] bus_rdat_o,
  output logic                  bus_ack_o,
  // Slaves
  output logic                  mem_stb_o,
  input  logic [DATA_WIDTH-1:0] mem_rdat_i,
  input  logic                  mem_ack_i,
  output logic                  gpio_stb_o,
  input  logic [DATA_WIDTH-1:0] gpio_rdat_i,
  input  logic                  gpio_ack_i
);

  region_e region;
  logic    dflt_ack_q;

  // ----------------------------------------
  // Region decode
  // ----------------------------------------
  always_comb begin
    case (bus_adr_i[REGION_MSB -: REGION_W])
      REGION_MEM:  region = RGN_MEM;
      REGION_GPIO: region = RGN_GPIO;
      default:     region = RGN_NONE;
    endcase
  end

  assign mem_stb_o  = bus_stb_i & (region == RGN_MEM);
  assign gpio_stb_o = bus_stb_i & (region == RGN_GPIO);

  // Unmapped access still gets an ack one cycle later
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dflt_ack_q <= 1'b0;
    end else begin
      dflt_ack_q <= bus_stb_i & (region == RGN_NONE) & ~dflt_ack_q;
    end
  end

  // ----------------------------------------
  // Response merge
  // ----------------------------------------
  always_comb begin
    case (region)
      RGN_MEM:  bus_rdat_o = mem_rdat_i;
      RGN_GPIO: bus_rdat_o = gpio_rdat_i;
      default:  bus_rdat_o = '0;
    endcase
  end

  assign bus_ack_o = mem_ack_i | gpio_ack_i | dflt_ack_q;

endmodule

// File: boot_mem.sv
// Boot memory slave, 256 words with a read-only version window
module boot_mem import sys_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  logic [MEM_AW-1:0]     adr_i,
  input  logic [DATA_WIDTH-1:0] wdat_i,
  output logic [DATA_WIDTH-1:0] rdat_o,
  output logic                  ack_o
);

  logic [DATA_WIDTH-1:0] mem_q [MEM_DEPTH];
  logic [DATA_WIDTH-1:0] ver_word;
  logic                  in_ver;
  logic                  access;

  // First cycle of a strobe only
  assign access = stb_i & ~ack_o;

  // Low indices map onto the version constant
  assign in_ver = (adr_i < VERSION_WORDS);

  // ----------------------------------------
  // Version word select
  // ----------------------------------------
  always_comb begin
    ver_word = '0;
    for (int i = 0; i < VERSION_WORDS; i++) begin
      if (adr_i == MEM_AW'(i)) begin
        ver_word = SYS_VERSION[i*DATA_WIDTH +: DATA_WIDTH];
      end
    end
  end

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  // Writes into the version window are dropped
  always_ff @(posedge clk) begin
    if (access && we_i && !in_ver) begin
      mem_q[adr_i] <= wdat_i;
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    if (access) begin
      rdat_o <= in_ver ? ver_word : mem_q[adr_i];
    end
  end

  // Single-cycle ack
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

endmodule

// File: gpio_ctrl.sv
// GPIO slave with direction, output and synchronized input registers
module gpio_ctrl import sys_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  gpio_reg_e             reg_i,
  input  logic [DATA_WIDTH-1:0] wdat_i,
  output logic [DATA_WIDTH-1:0] rdat_o,
  output logic                  ack_o,
  // Pins
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o
);

  logic [GPIO_WIDTH-1:0] dir_q;
  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] sync1_q;
  logic [GPIO_WIDTH-1:0] sync2_q;
  logic                  access;

  assign access = stb_i & ~ack_o;

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q <= '0;
      out_q <= '0;
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
      if (access && we_i) begin
        case (reg_i)
          GPIO_DIR: dir_q <= wdat_i[GPIO_WIDTH-1:0];
          GPIO_OUT: out_q <= wdat_i[GPIO_WIDTH-1:0];
          // Input register and code 3 ignore writes
          default: ;
        endcase
      end
    end
  end

  // Two-flop synchronizer on the input pins
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
    end
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (access) begin
      case (reg_i)
        GPIO_DIR: rdat_o <= DATA_WIDTH'(dir_q);
        GPIO_OUT: rdat_o <= DATA_WIDTH'(out_q);
        GPIO_IN:  rdat_o <= DATA_WIDTH'(sync2_q);
        default:  rdat_o <= '0;
      endcase
    end
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = dir_q;

endmodule

// File: system_top.sv
// System top level with arbiter, address decoder, boot memory and GPIO
module system_top import sys_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  // Master 0
  input  logic                  m0_cyc_i,
  input  logic                  m0_stb_i,
  input  logic                  m0_we_i,
  input  logic [ADDR_WIDTH-1:0] m0_adr_i,
  input  logic [DATA_WIDTH-1:0] m0_dat_i,
  output logic [DATA_WIDTH-1:0] m0_dat_o,
  output logic                  m0_ack_o,
  // Master 1
  input  logic                  m1_cyc_i,
  input  logic                  m1_stb_i,
  input  logic                  m1_we_i,
  input  logic [ADDR_WIDTH-1:0] m1_adr_i,
  input  logic [DATA_WIDTH-1:0] m1_dat_i,
  output logic [DATA_WIDTH-1:0] m1_dat_o,
  output logic                  m1_ack_o,
  // GPIO pins
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o
);

  // Shared bus
  logic                  bus_stb;
  logic                  bus_we;
  logic [ADDR_WIDTH-1:0] bus_adr;
  logic [DATA_WIDTH-1:0] bus_wdat;
  logic [DATA_WIDTH-1:0] bus_rdat;
  logic                  bus_ack;

  // Slave side
  logic                  mem_stb;
  logic [DATA_WIDTH-1:0] mem_rdat;
  logic                  mem_ack;
  logic                  gpio_stb;
  logic [DATA_WIDTH-1:0] gpio_rdat;
  logic                  gpio_ack;

  // ----------------------------------------
  // Arbitration
  // ----------------------------------------
  bus_arbiter u_arbiter (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .m0_cyc_i   (m0_cyc_i),
    .m0_stb_i   (m0_stb_i),
    .m0_we_i    (m0_we_i),
    .m0_adr_i   (m0_adr_i),
    .m0_dat_i   (m0_dat_i),
    .m0_dat_o   (m0_dat_o),
    .m0_ack_o   (m0_ack_o),
    .m1_cyc_i   (m1_cyc_i),
    .m1_stb_i   (m1_stb_i),
    .m1_we_i    (m1_we_i),
    .m1_adr_i   (m1_adr_i),
    .m1_dat_i   (m1_dat_i),
    .m1_dat_o   (m1_dat_o),
    .m1_ack_o   (m1_ack_o),
    .bus_stb_o  (bus_stb),
    .bus_we_o   (bus_we),
    .bus_adr_o  (bus_adr),
    .bus_wdat_o (bus_wdat),
    .bus_rdat_i (bus_rdat),
    .bus_ack_i  (bus_ack)
  );

  // ----------------------------------------
  // Decode and slaves
  // ----------------------------------------
  bus_decoder u_decoder (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .bus_stb_i   (bus_stb),
    .bus_adr_i   (bus_adr),
    .bus_rdat_o  (bus_rdat),
    .bus_ack_o   (bus_ack),
    .mem_stb_o   (mem_stb),
    .mem_rdat_i  (mem_rdat),
    .mem_ack_i   (mem_ack),
    .gpio_stb_o  (gpio_stb),
    .gpio_rdat_i (gpio_rdat),
    .gpio_ack_i  (gpio_ack)
  );

  // Word index from the low address bits
  boot_mem u_mem (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .stb_i    (mem_stb),
    .we_i     (bus_we),
    .adr_i    (bus_adr[MEM_AW-1:0]),
    .wdat_i   (bus_wdat),
    .rdat_o   (mem_rdat),
    .ack_o    (mem_ack)
  );

  gpio_ctrl u_gpio (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .stb_i     (gpio_stb),
    .we_i      (bus_we),
    .reg_i     (gpio_reg_e'(bus_adr[1:0])),
    .wdat_i    (bus_wdat),
    .rdat_o    (gpio_rdat),
    .ack_o     (gpio_ack),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

endmodule

// File: tb_system.sv
// Testbench for system_top with master tasks, reference model and checker
module tb_system import sys_pkg::*;;

  logic                  clk;
  logic                  arst_n_i;
  logic                  m0_cyc_i;
  logic                  m0_stb_i;
  logic                  m0_we_i;
  logic [ADDR_WIDTH-1:0] m0_adr_i;
  logic [DATA_WIDTH-1:0] m0_dat_i;
  logic [DATA_WIDTH-1:0] m0_dat_o;
  logic                  m0_ack_o;
  logic                  m1_cyc_i;
  logic                  m1_stb_i;
  logic                  m1_we_i;
  logic [ADDR_WIDTH-1:0] m1_adr_i;
  logic [DATA_WIDTH-1:0] m1_dat_i;
  logic [DATA_WIDTH-1:0] m1_dat_o;
  logic                  m1_ack_o;
  logic [GPIO_WIDTH-1:0] gpio_i;
  logic [GPIO_WIDTH-1:0] gpio_o;
  logic [GPIO_WIDTH-1:0] gpio_oe_o;

  // Model state
  logic [DATA_WIDTH-1:0] mem_model [MEM_DEPTH];
  logic [GPIO_WIDTH-1:0] dir_m = '0;
  logic [GPIO_WIDTH-1:0] out_m = '0;
  logic [GPIO_WIDTH-1:0] pin_m = '0;
  // Round-robin model starts as if m1 was served last
  logic                  last_m1_m = 1'b1;
  // Pending transfer of each master
  logic                  busy [2];
  logic                  req_we [2];
  logic [ADDR_WIDTH-1:0] req_adr [2];
  logic [DATA_WIDTH-1:0] req_dat [2];
  int                    seed = 32'h6d49_f912;
  int                    cycles = 0;
  bit                    failed;

  system_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic logic [DATA_WIDTH-1:0] ref_read(input logic [ADDR_WIDTH-1:0] adr);
    case (adr[14:12])
      3'b000: begin
        // Version words sit at indices 0 to 3
        if (adr[7:2] == 6'd0) begin
          case (adr[1:0])
            2'd0:    return SYS_VERSION[15:0];
            2'd1:    return SYS_VERSION[31:16];
            2'd2:    return SYS_VERSION[47:32];
            default: return SYS_VERSION[63:48];
          endcase
        end
        return mem_model[adr[7:0]];
      end
      3'b100: begin
        case (adr[1:0])
          2'd0:    return dir_m;
          2'd1:    return out_m;
          2'd2:    return pin_m;
          default: return '0;
        endcase
      end
      default: return '0;
    endcase
  endfunction

  task automatic model_write(input logic [ADDR_WIDTH-1:0] adr, input logic [15:0] dat);
    if (adr[14:12] == 3'b000 && adr[7:0] >= 4) mem_model[adr[7:0]] = dat;
    if (adr[14:12] == 3'b100 && adr[1:0] == 2'd0) dir_m = dat;
    if (adr[14:12] == 3'b100 && adr[1:0] == 2'd1) out_m = dat;
  endtask

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    failed = 1'b1;
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
    stop_with_failure($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // ----------------------------------------
  // Master side
  // ----------------------------------------
  task automatic drive_master(input int m, input logic req, input logic we,
                              input logic [14:0] adr, input logic [15:0] dat);
    if (m == 0) begin
      m0_cyc_i <= req;
      m0_stb_i <= req;
      m0_we_i  <= we;
      m0_adr_i <= adr;
      m0_dat_i <= dat;
    end else begin
      m1_cyc_i <= req;
      m1_stb_i <= req;
      m1_we_i  <= we;
      m1_adr_i <= adr;
      m1_dat_i <= dat;
    end
  endtask

  // Holds the request until ack and reports the wait and the ack cycle
  task automatic bus_access(input int m, input logic we, input logic [14:0] adr,
                            input logic [15:0] dat, output int lat, output int ack_cyc);
    @(posedge clk);
    req_we[m]  = we;
    req_adr[m] = adr;
    req_dat[m] = dat;
    busy[m]    = 1'b1;
    drive_master(m, 1'b1, we, adr, dat);
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end while (!(m == 0 ? m0_ack_o : m1_ack_o));
    ack_cyc = cycles;
    @(posedge clk);
    busy[m] = 1'b0;
    drive_master(m, 1'b0, 1'b0, '0, '0);
  endtask

  // Idle bus access with fixed latency
  task automatic idle_access(input int m, input logic we, input logic [14:0] adr,
                             input logic [15:0] dat);
    int lat;
    int ack_cyc;
    bus_access(m, we, adr, dat, lat, ack_cyc);
    assert (lat == 3) else value_mismatch("ack latency", 16'(lat), 16'd3);
  endtask

  // Both masters request on the same edge and the one not served last goes first
  task automatic tied_access(input logic we0, input logic [14:0] adr0,
                             input logic [15:0] dat0, input logic [14:0] adr1);
    int lat0;
    int lat1;
    int cyc0;
    int cyc1;
    bit m0_first;
    m0_first = last_m1_m;
    fork
      bus_access(0, we0, adr0, dat0, lat0, cyc0);
      bus_access(1, 1'b0, adr1, '0, lat1, cyc1);
    join
    assert ((cyc0 < cyc1) == m0_first)
      else stop_with_failure("Contention served the masters in the wrong order");
  endtask

  // ----------------------------------------
  // Response checker
  // ----------------------------------------
  // Retires one acked transfer against the model
  task automatic complete_access(input int m, input logic [15:0] got);
    logic [15:0] want;
    if (req_we[m]) begin
      model_write(req_adr[m], req_dat[m]);
    end else begin
      want = ref_read(req_adr[m]);
      assert (got == want)
        else value_mismatch(m == 0 ? "m0_dat_o" : "m1_dat_o", got, want);
    end
    last_m1_m = (m == 1);
  endtask

  always @(negedge clk) begin
    if (arst_n_i) begin
      if (m0_ack_o) begin
        assert (busy[0] && !m1_ack_o)
          else stop_with_failure("Ack on master 0 without its own pending request");
        complete_access(0, m0_dat_o);
      end
      if (m1_ack_o) begin
        assert (busy[1] && !m0_ack_o)
          else stop_with_failure("Ack on master 1 without its own pending request");
        complete_access(1, m1_dat_o);
      end
    end
  end

  // Run limit of about four times the test length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= 4000) stop_with_failure("Timeout: the tests did not finish in 4000 cycles");
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    logic [14:0] adr;
    logic [15:0] dat;
    logic [14:0] list [$];
    arst_n_i <= 1'b0;
    m0_cyc_i <= 1'b0;
    m0_stb_i <= 1'b0;
    m0_we_i  <= 1'b0;
    m0_adr_i <= '0;
    m0_dat_i <= '0;
    m1_cyc_i <= 1'b0;
    m1_stb_i <= 1'b0;
    m1_we_i  <= 1'b0;
    m1_adr_i <= '0;
    m1_dat_i <= '0;
    gpio_i   <= '0;
    failed = 1'b0;
    for (int i = 0; i < 2; i++) begin
      busy[i] = 1'b0;
      req_we[i] = 1'b0;
      req_adr[i] = '0;
      req_dat[i] = '0;
    end
    repeat (10) @(posedge clk);
    arst_n_i <= 1'b1;
    repeat (2) @(posedge clk);

    // First tie after reset
    tied_access(1'b0, 15'd0, '0, 15'd1);

    // Version words and a dropped write
    for (int i = 0; i < 4; i++) idle_access(0, 1'b0, 15'(i), '0);
    idle_access(0, 1'b1, 15'd2, 16'hDEAD);
    idle_access(0, 1'b0, 15'd2, '0);

    // Random memory words with the masters taking turns
    for (int i = 0; i < 40; i++) begin
      adr = 15'(4 + ($unsigned($random(seed)) % 252));
      dat = 16'($random(seed));
      idle_access(i % 2, 1'b1, adr, dat);
      idle_access((i + 1) % 2, 1'b0, adr, '0);
      list.push_back(adr);
    end

    // Both masters request on the same edge
    for (int r = 0; r < 30; r++) begin
      adr = list[r];
      dat = 16'($random(seed));
      tied_access(1'b1, adr, dat, list[r + 1]);
      idle_access(1, 1'b0, adr, '0);
    end

    // GPIO registers and pins
    idle_access(0, 1'b1, 15'h4000, 16'hA5C3);
    idle_access(1, 1'b1, 15'h4001, 16'h3C96);
    @(negedge clk);
    assert (gpio_oe_o == dir_m) else value_mismatch("gpio_oe_o", gpio_oe_o, dir_m);
    assert (gpio_o == out_m) else value_mismatch("gpio_o", gpio_o, out_m);
    idle_access(0, 1'b0, 15'h4000, '0);
    idle_access(1, 1'b0, 15'h4001, '0);
    @(posedge clk);
    gpio_i <= 16'h71E4;
    pin_m = 16'h71E4;
    repeat (3) @(posedge clk);
    idle_access(0, 1'b0, 15'h4002, '0);
    idle_access(1, 1'b1, 15'h4002, 16'hFFFF);
    idle_access(1, 1'b1, 15'h4003, 16'hFFFF);
    idle_access(0, 1'b0, 15'h4002, '0);
    idle_access(0, 1'b0, 15'h4003, '0);

    // Unmapped regions alias nothing
    idle_access(0, 1'b1, 15'h2000 | list[0], 16'h1234);
    idle_access(1, 1'b1, 15'h6000, 16'h5678);
    idle_access(1, 1'b1, 15'h6001, 16'h9ABC);
    idle_access(0, 1'b0, 15'h2000 | list[0], '0);
    idle_access(1, 1'b0, 15'h6001, '0);
    idle_access(0, 1'b0, list[0], '0);
    idle_access(1, 1'b0, 15'h4000, '0);
    idle_access(0, 1'b0, 15'h4001, '0);

    if (!failed) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: sim.f
sys_pkg.sv
bus_arbiter.sv
bus_decoder.sv
boot_mem.sv
gpio_ctrl.sv
system_top.sv
tb_system.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_system -o vsim
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

./obj_dir/vsim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -q "PASS: all tests" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
